// ==== sources.f ====
src/cp0Pkg.sv
src/cp0ExcRegs.sv
src/cp0Timer.sv
src/cp0IntrRead.sv
src/cp0Top.sv
sim/cp0Checker.sv
sim/cp0Tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cp0Tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator exit code does not
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/cp0Tb.sv ====
`timescale 1ns/10ps

module cp0Tb import cp0Pkg::*; ();

    localparam word_t resetVector  = 32'hBFC00000;
    localparam word_t prIdValue    = 32'h00018000;
    localparam int    testCycles   = 450;   // Sum over all tests rounded up
    localparam int    marginCycles = 100;
    localparam int    watchdogNs   = (testCycles + marginCycles) * 100;

    logic       clk;
    logic       rst;
    regAddr_t   regAddr;
    logic       regWen;
    word_t      regWdata;
    logic       excFlag;
    excType_t   excType;
    word_t      excPc;
    word_t      excBadAddr;
    logic [1:0] excCpNum;
    logic       excStore;
    logic       inDelaySlot;
    logic [5:0] hwIntr;
    word_t      regRdata;
    word_t      epc;
    word_t      errorEpc;
    logic       userMode;
    logic       excIntr;

    int          errCount;
    int          checkCount;
    int          tbErrors;
    int          errAtStart;
    logic [31:0] rngState;

    cp0Top #(
        .resetVector(resetVector),
        .prIdValue  (prIdValue)
    ) u_cp0Top (
        .clk(clk), .rst(rst),
        .regAddr_i(regAddr), .regWen_i(regWen), .regWdata_i(regWdata),
        .excFlag_i(excFlag), .excType_i(excType), .excPc_i(excPc),
        .excBadAddr_i(excBadAddr), .excCpNum_i(excCpNum), .excStore_i(excStore),
        .inDelaySlot_i(inDelaySlot), .hwIntr_i(hwIntr),
        .regRdata_o(regRdata), .epc_o(epc), .errorEpc_o(errorEpc),
        .userMode_o(userMode), .excIntr_o(excIntr)
    );

    cp0Checker #(
        .resetVector(resetVector),
        .prIdValue  (prIdValue)
    ) u_cp0Checker (
        .clk(clk), .rst(rst),
        .regAddr_i(regAddr), .regWen_i(regWen), .regWdata_i(regWdata),
        .excFlag_i(excFlag), .excType_i(excType), .excPc_i(excPc),
        .excBadAddr_i(excBadAddr), .excCpNum_i(excCpNum), .excStore_i(excStore),
        .inDelaySlot_i(inDelaySlot), .hwIntr_i(hwIntr),
        .regRdata_i(regRdata), .epc_i(epc), .errorEpc_i(errorEpc),
        .userMode_i(userMode), .excIntr_i(excIntr),
        .errCount_o(errCount), .checkCount_o(checkCount)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output word_t w);
        rngState = xorshift32(rngState);
        w = rngState;
    endtask

    function automatic regAddr_t writableReg(input int idx);
        case (idx)
            0:       return RegStatus;
            1:       return RegCause;
            2:       return RegEpc;
            3:       return RegBadVAddr;
            4:       return RegErrorEpc;
            5:       return RegCompare;
            default: return RegCount;
        endcase
    endfunction

    task automatic writeReg(input regAddr_t addr, input word_t data);
        @(posedge clk);
        regAddr  <= addr;
        regWen   <= 1'b1;
        regWdata <= data;
        excFlag  <= 1'b0;
    endtask

    task automatic readReg(input regAddr_t addr);
        @(posedge clk);
        regAddr <= addr;
        regWen  <= 1'b0;
        excFlag <= 1'b0;
    endtask

    task automatic setHw(input logic [5:0] lines);
        @(posedge clk);
        hwIntr  <= lines;
        regWen  <= 1'b0;
        excFlag <= 1'b0;
    endtask

    // One exception cycle with an optional competing register write
    task automatic raiseExc(input excType_t t, input word_t pc, input word_t bad,
                            input logic ds, input logic store, input logic [1:0] cp,
                            input logic wen, input regAddr_t addr, input word_t data);
        @(posedge clk);
        excFlag     <= 1'b1;
        excType     <= t;
        excPc       <= pc;
        excBadAddr  <= bad;
        inDelaySlot <= ds;
        excStore    <= store;
        excCpNum    <= cp;
        regWen      <= wen;
        regAddr     <= addr;
        regWdata    <= data;
    endtask

    task automatic waitIntr(input int maxCycles, input string source);
        int n;
        n = 0;
        @(negedge clk);
        while (!excIntr && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (!excIntr) begin
            $display("%s interrupt did not reach excIntr_o within %0d cycles", source, maxCycles);
            tbErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        int delta;
        @(negedge clk);
        #1;
        delta = errCount + tbErrors - errAtStart;
        $display("%s: finished with %0d errors", name, delta);
        errAtStart = errCount + tbErrors;
    endtask

    task automatic testReset();
        int a;
        for (a = 0; a < 32; a++) begin
            readReg(regAddr_t'(a));
        end
    endtask

    task automatic testWriteBack();
        word_t r;
        int i;
        int j;
        for (i = 0; i < 7; i++) begin
            for (j = 0; j < 4; j++) begin
                nextRandom(r);
                writeReg(writableReg(i), r);
                readReg(writableReg(i));
            end
        end
    endtask

    task automatic testExceptions();
        word_t pc;
        word_t bad;
        int s;
        int k;
        for (s = 0; s < 2; s++) begin   // Load codes first then store codes
            for (k = 1; k <= 11; k++) begin   // ExcIntr through ExcTlbm
                writeReg(RegStatus, 32'h0);
                nextRandom(pc);
                nextRandom(bad);
                raiseExc(excType_t'(k), pc, bad, k[0], s[0], k[2:1], 1'b0, RegStatus, 32'h0);
                readReg(RegCause);
                readReg(RegEpc);
                readReg(RegBadVAddr);
            end
        end
        writeReg(RegStatus, 32'h0);
        nextRandom(pc);
        raiseExc(ExcSysc, pc, bad, 1'b0, 1'b0, 2'd0, 1'b0, RegEpc, 32'h0);
        nextRandom(pc);
        raiseExc(ExcRi, pc, bad, 1'b1, 1'b0, 2'd0, 1'b0, RegEpc, 32'h0);   // EXL already set
        readReg(RegEpc);
        readReg(RegCause);
        raiseExc(ExcEret, pc, bad, 1'b0, 1'b0, 2'd0, 1'b0, RegStatus, 32'h0);
        readReg(RegStatus);
        nextRandom(pc);
        nextRandom(bad);
        raiseExc(ExcBp, pc, bad, 1'b0, 1'b0, 2'd0, 1'b1, RegEpc, bad);
        readReg(RegEpc);
        nextRandom(bad);
        raiseExc(ExcOv, pc, bad, 1'b0, 1'b0, 2'd0, 1'b1, RegCount, bad);
        readReg(RegCount);
        readReg(RegCount);
    endtask

    task automatic testTimer();
        word_t v;
        int i;
        nextRandom(v);
        v = v & 32'h0FFF_FFF0;
        writeReg(RegCompare, 32'h0);
        writeReg(RegCause, 32'h0);
        writeReg(RegStatus, 32'h0000_8001);   // IM7 and IE only
        writeReg(RegCount, v);
        for (i = 0; i < 4; i++) begin
            readReg(RegCount);
        end
        writeReg(RegCompare, v + 32'd12);
        readReg(RegCount);
        waitIntr(40, "Timer");
        writeReg(RegCompare, 32'h0);
        readReg(RegCause);
        readReg(RegCause);
    endtask

    task automatic testInterrupts();
        word_t r;
        int i;
        writeReg(RegCause, 32'h0);
        writeReg(RegStatus, 32'h0000_FF01);
        setHw(6'b000001);
        waitIntr(4, "Hardware");
        writeReg(RegStatus, 32'h0000_FF03);   // EXL blocks it
        writeReg(RegStatus, 32'h0000_FF05);   // ERL too
        setHw(6'b000000);
        writeReg(RegStatus, 32'h0000_0101);
        writeReg(RegCause, 32'h0000_0100);    // Software IP0
        waitIntr(4, "Software");
        writeReg(RegStatus, 32'h0000_0010);
        writeReg(RegStatus, 32'h0000_0012);
        for (i = 0; i < 16; i++) begin
            nextRandom(r);
            writeReg(RegStatus, r & 32'h0000_FF17);
            setHw(r[21:16]);
            writeReg(RegCause, r & 32'h0000_0300);
            readReg(RegCause);
        end
        setHw(6'b000000);
    endtask

    initial begin
        int total;
        clk = 1'b0;
        rst = 1'b1;
        regAddr = '0;
        regWen = 1'b0;
        regWdata = '0;
        excFlag = 1'b0;
        excType = ExcNone;
        excPc = '0;
        excBadAddr = '0;
        excCpNum = '0;
        excStore = 1'b0;
        inDelaySlot = 1'b0;
        hwIntr = '0;
        tbErrors = 0;
        errAtStart = 0;
        rngState = 32'hee2d07d4;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testReset();
        finishTest("Reset values");
        testWriteBack();
        finishTest("Write and read-back");
        testExceptions();
        finishTest("Exception recording");
        testTimer();
        finishTest("Count and Compare");
        testInterrupts();
        finishTest("Interrupts and user mode");
        total = errCount + tbErrors;
        $display("Summary: %0d checks, %0d errors", checkCount, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns before the tests finished", watchdogNs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== sim/cp0Checker.sv ====
`timescale 1ns/10ps

module cp0Checker import cp0Pkg::*; #(
    parameter word_t resetVector = 32'hBFC00000,
    parameter word_t prIdValue   = 32'h00018000
) (
    input  logic       clk,
    input  logic       rst,
    input  regAddr_t   regAddr_i,
    input  logic       regWen_i,
    input  word_t      regWdata_i,
    input  logic       excFlag_i,
    input  excType_t   excType_i,
    input  word_t      excPc_i,
    input  word_t      excBadAddr_i,
    input  logic [1:0] excCpNum_i,
    input  logic       excStore_i,
    input  logic       inDelaySlot_i,
    input  logic [5:0] hwIntr_i,
    input  word_t      regRdata_i,
    input  word_t      epc_i,
    input  word_t      errorEpc_i,
    input  logic       userMode_i,
    input  logic       excIntr_i,
    output int         errCount_o,
    output int         checkCount_o
);

    // Model state, Cause kept with IP[1:0] in place and IP[7:2] apart
    word_t       mStatus;
    word_t       mCause;
    word_t       mEpc;
    word_t       mBad;
    word_t       mErrEpc;
    word_t       mCompare;
    logic [32:0] mCountFull;
    logic        mTimerIrq;
    logic [5:0]  mHwIp;

    // Inputs as seen mid-cycle, applied at the next edge
    logic       sWen;
    regAddr_t   sAddr;
    word_t      sWdata;
    logic       sExc;
    excType_t   sType;
    word_t      sPc;
    word_t      sBad;
    logic [1:0] sCp;
    logic       sStore;
    logic       sDs;
    logic [5:0] sHw;

    int errCount = 0;
    int checkCount = 0;

    function automatic excCode_t codeFor(input excType_t t, input logic store);
        case (t)
            ExcCpU:           return CodeCpU;
            ExcRi:            return CodeRi;
            ExcOv:            return CodeOv;
            ExcTrap:          return CodeTr;
            ExcSysc:          return CodeSys;
            ExcBp:            return CodeBp;
            ExcAdE:           return store ? CodeAdes : CodeAdel;
            ExcTlbr, ExcTlbi: return store ? CodeTlbs : CodeTlbl;
            ExcTlbm:          return CodeMod;
            default:          return CodeInt;
        endcase
    endfunction

    // Reference for the read port
    function automatic word_t expectRead(input regAddr_t addr);
        word_t cause;
        cause = mCause;
        cause[15:10] = mHwIp;
        case (addr)
            RegBadVAddr: return mBad;
            RegCount:    return mCountFull[32:1];
            RegCompare:  return mCompare;
            RegStatus:   return mStatus;
            RegCause:    return cause;
            RegEpc:      return mEpc;
            RegPrId:     return prIdValue;
            RegErrorEpc: return mErrEpc;
            default:     return 32'h0;
        endcase
    endfunction

    function automatic logic expectIntr();
        return |({mHwIp, mCause[9:8]} & mStatus[15:8]) && mStatus[0]
            && !mStatus[1] && !mStatus[2];
    endfunction

    function automatic logic expectUser();
        return mStatus[4] && !mStatus[1] && !mStatus[2];
    endfunction

    task automatic resetModel();
        mStatus    = 32'h0040_0004;   // BEV and ERL
        mCause     = 32'h0;
        mEpc       = 32'h0;
        mBad       = 32'h0;
        mErrEpc    = resetVector;
        mCompare   = 32'h0;
        mCountFull = 33'h0;
        mTimerIrq  = 1'b0;
        mHwIp      = 6'h0;
    endtask

    task automatic stepModel();
        word_t count;
        logic  irqNow;
        count  = mCountFull[32:1];
        irqNow = mTimerIrq;
        mHwIp  = {sHw[5] | irqNow, sHw[4:0]};
        if (sWen && sAddr == RegCount)
            mCountFull = {sWdata, 1'b0};   // Timer ignores exceptions
        else
            mCountFull = mCountFull + 33'd1;
        if (sWen && sAddr == RegCompare) begin
            mCompare  = sWdata;
            mTimerIrq = 1'b0;
        end else if (mCompare != 32'h0 && count == mCompare) begin
            mTimerIrq = 1'b1;
        end
        if (sExc) begin
            if (sType == ExcEret) begin
                mStatus[1] = 1'b0;
            end else if (sType != ExcNone) begin
                if (!mStatus[1]) begin
                    mEpc      = sDs ? sPc - 32'd4 : sPc;
                    mCause[31] = sDs;
                end
                mStatus[1]   = 1'b1;
                mCause[6:2]  = codeFor(sType, sStore);
                if (sType inside {ExcAdE, ExcTlbr, ExcTlbi, ExcTlbm})
                    mBad = sBad;
                if (sType == ExcCpU)
                    mCause[29:28] = sCp;
            end
        end else if (sWen) begin
            case (sAddr)
                RegStatus:   mStatus = sWdata & 32'h1040_FF17;
                RegCause:    mCause = (mCause & ~32'h0080_0300) | (sWdata & 32'h0080_0300);
                RegEpc:      mEpc = sWdata;
                RegBadVAddr: mBad = sWdata;
                RegErrorEpc: mErrEpc = sWdata;
                default: ;
            endcase
        end
    endtask

    task automatic checkValue(input string what, input word_t got, input word_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst)
            resetModel();
        else
            stepModel();
    end

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checkValue($sformatf("regRdata_o of reg %0d", regAddr_i), regRdata_i,
                       expectRead(regAddr_i));
            checkValue("excIntr_o", word_t'(excIntr_i), word_t'(expectIntr()));
            checkValue("userMode_o", word_t'(userMode_i), word_t'(expectUser()));
            checkValue("epc_o", epc_i, mEpc);
            checkValue("errorEpc_o", errorEpc_i, mErrEpc);
        end
        sWen   = regWen_i;
        sAddr  = regAddr_i;
        sWdata = regWdata_i;
        sExc   = excFlag_i;
        sType  = excType_i;
        sPc    = excPc_i;
        sBad   = excBadAddr_i;
        sCp    = excCpNum_i;
        sStore = excStore_i;
        sDs    = inDelaySlot_i;
        sHw    = hwIntr_i;
    end

    assign errCount_o   = errCount;
    assign checkCount_o = checkCount;

endmodule

// ==== src/cp0Top.sv ====
`timescale 1ns/10ps

module cp0Top import cp0Pkg::*; #(
    parameter word_t resetVector = 32'hBFC00000,
    parameter word_t prIdValue   = 32'h00018000
) (
    input  logic       clk,
    input  logic       rst,
    input  regAddr_t   regAddr_i,
    input  logic       regWen_i,
    input  word_t      regWdata_i,
    input  logic       excFlag_i,
    input  excType_t   excType_i,
    input  word_t      excPc_i,
    input  word_t      excBadAddr_i,
    input  logic [1:0] excCpNum_i,
    input  logic       excStore_i,
    input  logic       inDelaySlot_i,
    input  logic [5:0] hwIntr_i,
    output word_t      regRdata_o,
    output word_t      epc_o,
    output word_t      errorEpc_o,
    output logic       userMode_o,
    output logic       excIntr_o
);

    word_t      status;
    word_t      causeCtl;
    logic [1:0] swIp;
    word_t      badVAddr;
    word_t      count;
    word_t      compare;
    logic       timerIrq;

    cp0ExcRegs #(
        .resetVector(resetVector)
    ) u_cp0ExcRegs (
        .clk          (clk),
        .rst          (rst),
        .excFlag_i    (excFlag_i),
        .excType_i    (excType_i),
        .excPc_i      (excPc_i),
        .excBadAddr_i (excBadAddr_i),
        .excCpNum_i   (excCpNum_i),
        .excStore_i   (excStore_i),
        .inDelaySlot_i(inDelaySlot_i),
        .regAddr_i    (regAddr_i),
        .regWen_i     (regWen_i),
        .regWdata_i   (regWdata_i),
        .status_o     (status),
        .causeCtl_o   (causeCtl),
        .swIp_o       (swIp),
        .epc_o        (epc_o),
        .badVAddr_o   (badVAddr),
        .errorEpc_o   (errorEpc_o)
    );

    // Count writes bypass the exception priority
    cp0Timer u_cp0Timer (
        .clk       (clk),
        .rst       (rst),
        .regAddr_i (regAddr_i),
        .regWen_i  (regWen_i),
        .regWdata_i(regWdata_i),
        .count_o   (count),
        .compare_o (compare),
        .timerIrq_o(timerIrq)
    );

    cp0IntrRead #(
        .prIdValue(prIdValue)
    ) u_cp0IntrRead (
        .clk       (clk),
        .rst       (rst),
        .hwIntr_i  (hwIntr_i),
        .timerIrq_i(timerIrq),
        .swIp_i    (swIp),
        .status_i  (status),
        .causeCtl_i(causeCtl),
        .epc_i     (epc_o),
        .badVAddr_i(badVAddr),
        .errorEpc_i(errorEpc_o),
        .count_i   (count),
        .compare_i (compare),
        .regAddr_i (regAddr_i),
        .regRdata_o(regRdata_o),
        .excIntr_o (excIntr_o),
        .userMode_o(userMode_o)
    );

endmodule

// ==== src/cp0IntrRead.sv ====
`timescale 1ns/10ps

module cp0IntrRead import cp0Pkg::*; #(
    parameter word_t prIdValue = 32'h00018000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] hwIntr_i,
    input  logic       timerIrq_i,
    input  logic [1:0] swIp_i,
    input  word_t      status_i,
    input  word_t      causeCtl_i,
    input  word_t      epc_i,
    input  word_t      badVAddr_i,
    input  word_t      errorEpc_i,
    input  word_t      count_i,
    input  word_t      compare_i,
    input  regAddr_t   regAddr_i,
    output word_t      regRdata_o,
    output logic       excIntr_o,
    output logic       userMode_o
);

    logic [7:2] hwIp;
    logic [7:0] ip;
    logic       noExcLevel;
    cp0Word_u   statusWord;
    cp0Word_u   causeWord;
    word_t      rdata;

    // Line 5 shared with the timer, as on MIPS32 without VInt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hwIp <= '0;
        end else begin
            hwIp <= {hwIntr_i[5] | timerIrq_i, hwIntr_i[4:0]};
        end
    end

    assign ip             = {hwIp, swIp_i};
    assign statusWord.raw = status_i;

    always_comb begin
        causeWord.raw      = causeCtl_i;
        causeWord.cause.ip = ip;
    end

    assign noExcLevel = !statusWord.status.exl && !statusWord.status.erl;

    assign excIntr_o  = |(ip & statusWord.status.im) && statusWord.status.ie && noExcLevel;
    assign userMode_o = statusWord.status.um && noExcLevel;

    always_comb begin
        case (regAddr_i)
            RegBadVAddr: rdata = badVAddr_i;
            RegCount:    rdata = count_i;
            RegCompare:  rdata = compare_i;
            RegStatus:   rdata = statusWord.raw;
            RegCause:    rdata = causeWord.raw;
            RegEpc:      rdata = epc_i;
            RegPrId:     rdata = prIdValue;
            RegErrorEpc: rdata = errorEpc_i;
            default:     rdata = '0;   // Unimplemented registers
        endcase
    end

    assign regRdata_o = rdata;

endmodule

// ==== src/cp0Timer.sv ====
`timescale 1ns/10ps

module cp0Timer import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t regAddr_i,
    input  logic     regWen_i,
    input  word_t    regWdata_i,
    output word_t    count_o,
    output word_t    compare_o,
    output logic     timerIrq_o
);

    logic [32:0] countFull;   // Extra low bit halves the rate
    word_t       count;
    word_t       compare;
    logic        timerIrq;
    logic        timerHit;

    assign count    = countFull[32:1];
    assign timerHit = (compare != '0) && (count == compare);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countFull <= '0;
        end else if (regWen_i && regAddr_i == RegCount) begin
            countFull <= {regWdata_i, 1'b0};
        end else begin
            countFull <= countFull + 33'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            compare  <= '0;
            timerIrq <= 1'b0;
        end else if (regWen_i && regAddr_i == RegCompare) begin
            compare  <= regWdata_i;
            timerIrq <= 1'b0;   // Writing Compare acks the timer
        end else if (timerHit) begin
            timerIrq <= 1'b1;
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerIrq_o = timerIrq;

endmodule

// ==== src/cp0ExcRegs.sv ====
`timescale 1ns/10ps

module cp0ExcRegs import cp0Pkg::*; #(
    parameter word_t resetVector = 32'hBFC00000
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     excFlag_i,
    input  excType_t excType_i,
    input  word_t    excPc_i,
    input  word_t    excBadAddr_i,
    input  logic [1:0] excCpNum_i,
    input  logic     excStore_i,
    input  logic     inDelaySlot_i,
    input  regAddr_t regAddr_i,
    input  logic     regWen_i,
    input  word_t    regWdata_i,
    output word_t    status_o,
    output word_t    causeCtl_o,
    output logic [1:0] swIp_o,
    output word_t    epc_o,
    output word_t    badVAddr_o,
    output word_t    errorEpc_o
);

    logic       statusCu0;
    logic       statusBev;
    logic [7:0] statusIm;
    logic       statusUm;
    logic       statusErl;
    logic       statusExl;
    logic       statusIe;

    logic       causeBd;
    logic [1:0] causeCe;
    logic       causeIv;
    logic [1:0] swIp;
    excCode_t   causeExcCode;

    word_t epc;
    word_t badVAddr;
    word_t errorEpc;

    cp0Word_u wrWord;
    cp0Word_u statusWord;
    cp0Word_u causeWord;
    excCode_t excCode;
    logic     isRecorded;    // Any real exception, ERET excluded
    logic     recordAddr;
    word_t    savedPc;

    assign wrWord.raw = regWdata_i;
    assign savedPc    = inDelaySlot_i ? excPc_i - 32'd4 : excPc_i;

    always_comb begin
        isRecorded = 1'b1;
        recordAddr = 1'b0;
        case (excType_i)
            ExcIntr: excCode = CodeInt;
            ExcCpU:  excCode = CodeCpU;
            ExcRi:   excCode = CodeRi;
            ExcOv:   excCode = CodeOv;
            ExcTrap: excCode = CodeTr;
            ExcSysc: excCode = CodeSys;
            ExcBp:   excCode = CodeBp;
            ExcAdE: begin
                excCode    = excStore_i ? CodeAdes : CodeAdel;
                recordAddr = 1'b1;
            end
            ExcTlbr, ExcTlbi: begin
                excCode    = excStore_i ? CodeTlbs : CodeTlbl;
                recordAddr = 1'b1;
            end
            ExcTlbm: begin
                excCode    = CodeMod;
                recordAddr = 1'b1;
            end
            default: begin   // ExcNone and ERET
                excCode    = causeExcCode;
                isRecorded = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusCu0    <= 1'b0;
            statusBev    <= 1'b1;
            statusIm     <= '0;
            statusUm     <= 1'b0;
            statusErl    <= 1'b1;
            statusExl    <= 1'b0;
            statusIe     <= 1'b0;
            causeBd      <= 1'b0;
            causeCe      <= '0;
            causeIv      <= 1'b0;
            swIp         <= '0;
            causeExcCode <= '0;
            epc          <= '0;
            badVAddr     <= '0;
            errorEpc     <= resetVector;
        end else if (excFlag_i) begin
            if (excType_i == ExcEret) begin
                statusExl <= 1'b0;
            end else if (isRecorded) begin
                statusExl    <= 1'b1;
                causeExcCode <= excCode;
                if (!statusExl) begin   // Nested exception keeps first EPC
                    epc     <= savedPc;
                    causeBd <= inDelaySlot_i;
                end
                if (recordAddr)
                    badVAddr <= excBadAddr_i;
                if (excType_i == ExcCpU)
                    causeCe <= excCpNum_i;
            end
        end else if (regWen_i) begin
            case (regAddr_i)
                RegStatus: begin
                    statusCu0 <= wrWord.status.cu0;
                    statusBev <= wrWord.status.bev;
                    statusIm  <= wrWord.status.im;
                    statusUm  <= wrWord.status.um;
                    statusErl <= wrWord.status.erl;
                    statusExl <= wrWord.status.exl;
                    statusIe  <= wrWord.status.ie;
                end
                RegCause: begin
                    causeIv <= wrWord.cause.iv;
                    swIp    <= wrWord.cause.ip[1:0];
                end
                RegEpc:      epc      <= regWdata_i;
                RegBadVAddr: badVAddr <= regWdata_i;
                RegErrorEpc: errorEpc <= regWdata_i;
                default: ;
            endcase
        end
    end

    always_comb begin
        statusWord.raw        = '0;
        statusWord.status.cu0 = statusCu0;
        statusWord.status.bev = statusBev;
        statusWord.status.im  = statusIm;
        statusWord.status.um  = statusUm;
        statusWord.status.erl = statusErl;
        statusWord.status.exl = statusExl;
        statusWord.status.ie  = statusIe;
    end

    // IP left zero here, filled in by the read side
    always_comb begin
        causeWord.raw           = '0;
        causeWord.cause.bd      = causeBd;
        causeWord.cause.ce      = causeCe;
        causeWord.cause.iv      = causeIv;
        causeWord.cause.excCode = causeExcCode;
    end

    assign status_o   = statusWord.raw;
    assign causeCtl_o = causeWord.raw;
    assign swIp_o     = swIp;
    assign epc_o      = epc;
    assign badVAddr_o = badVAddr;
    assign errorEpc_o = errorEpc;

endmodule

// ==== src/cp0Pkg.sv ====
package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // CP0 register numbers, select 0
    localparam regAddr_t RegBadVAddr = 5'd8;
    localparam regAddr_t RegCount    = 5'd9;
    localparam regAddr_t RegCompare  = 5'd11;
    localparam regAddr_t RegStatus   = 5'd12;
    localparam regAddr_t RegCause    = 5'd13;
    localparam regAddr_t RegEpc      = 5'd14;
    localparam regAddr_t RegPrId     = 5'd15;
    localparam regAddr_t RegErrorEpc = 5'd30;

    // Exception kinds reported by the pipeline
    typedef enum logic [3:0] {
        ExcNone,
        ExcIntr,
        ExcCpU,
        ExcRi,
        ExcOv,
        ExcTrap,
        ExcSysc,
        ExcBp,
        ExcAdE,
        ExcTlbr,
        ExcTlbi,
        ExcTlbm,
        ExcEret
    } excType_t;

    typedef logic [4:0] excCode_t;

    localparam excCode_t CodeInt  = 5'd0;
    localparam excCode_t CodeMod  = 5'd1;
    localparam excCode_t CodeTlbl = 5'd2;
    localparam excCode_t CodeTlbs = 5'd3;
    localparam excCode_t CodeAdel = 5'd4;
    localparam excCode_t CodeAdes = 5'd5;
    localparam excCode_t CodeSys  = 5'd8;
    localparam excCode_t CodeBp   = 5'd9;
    localparam excCode_t CodeRi   = 5'd10;
    localparam excCode_t CodeCpU  = 5'd11;
    localparam excCode_t CodeOv   = 5'd12;
    localparam excCode_t CodeTr   = 5'd13;

    typedef struct packed {
        logic [2:0] pad31;
        logic       cu0;        // 28
        logic [4:0] pad27;
        logic       bev;        // 22
        logic [5:0] pad21;
        logic [7:0] im;         // 15:8
        logic [2:0] pad7;
        logic       um;         // 4
        logic       pad3;
        logic       erl;        // 2
        logic       exl;        // 1
        logic       ie;         // 0
    } statusView_t;

    typedef struct packed {
        logic       bd;         // 31
        logic       pad30;
        logic [1:0] ce;         // 29:28
        logic [3:0] pad27;
        logic       iv;         // 23
        logic [6:0] pad22;
        logic [7:0] ip;         // 15:8, only 9:8 writable
        logic       pad7;
        excCode_t   excCode;    // 6:2
        logic [1:0] pad1;
    } causeView_t;

    // Same data word seen as Status or Cause
    typedef union packed {
        word_t       raw;
        statusView_t status;
        causeView_t  cause;
    } cp0Word_u;

endpackage
